//--- Makefile
LOG := sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f sliced_alu.f --top-module sliced_alu_tb -Mdir obj_dir

# a crash or assertion stop also counts as a failed run
run: compile
	./obj_dir/Vsliced_alu_tb > $(LOG) 2>&1 || echo "Some tests failed" >> $(LOG)
	cat $(LOG)
	! grep -q "Some tests failed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- bench/sliced_alu_tb.sv
`default_nettype none

module sliced_alu_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import alu_pkg::*;
    import bus_pkg::*;

    localparam int N_ADDSUB   = 300;
    localparam int N_RAND     = 50; // per logic command, for compare and for shift
    localparam int N_STALL    = 10; // add and sub pairs under long back-pressure
    localparam int OPS        = 2 * N_ADDSUB + 4 * (N_RAND + 2) + 2 * N_RAND + 9 + 2 * N_STALL;
    localparam int TXN_CYCLES = 40; // generous bound for one bus transaction with stalls
    localparam int TIMEOUT    = 16 + (5 * OPS + 10) * TXN_CYCLES;

    localparam alu_cmd_e    LOGIC_CMDS [4]     = '{XOR, XNOR, AND, OR};
    localparam logic [15:0] SHIFT_PATTERNS [8] = '{16'h1111, 16'h0010, 16'h0100, 16'h1000,
                                                   16'h8888, 16'hFFFF, 16'h0001, 16'hF0F1};

    logic      clk;
    logic      arst_n;
    axil_req_t req;
    axil_rsp_t rsp;

    int          seed       = 9259;
    int          mismatches = 0;
    int          failures   = 0;
    int          max_stall  = 3;
    logic [15:0] model_result = '0; // last result the model knows the DUT holds

    sliced_alu_top #(.WIDTH(16)) DUT (.clk(clk), .arst_n(arst_n), .req(req), .rsp(rsp));

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        mismatches++;
        $display("Mismatch at %0t ns: %s got 0x%0h, expected 0x%0h", $time, name, got, expected);
    endtask

    task automatic report_failure(input string what);
        failures++;
        $display("Failure at %0t ns: %s", $time, what);
    endtask

    function automatic int stall_cycles();
        return {$random(seed)} % (max_stall + 1);
    endfunction

    task automatic bus_write(input logic [7:0] addr, input logic [31:0] data,
                             input axil_resp_t expected);
        int         stall;
        axil_resp_t resp;
        stall = stall_cycles();
        @(posedge clk);
        req.awvalid <= 1'b1;
        req.awaddr  <= addr;
        req.wvalid  <= 1'b1;
        req.wdata   <= data;
        req.wstrb   <= 4'hF;
        do begin
            @(negedge clk);
        end while (!(rsp.awready && rsp.wready));
        @(posedge clk); // address and data are taken on this edge
        req.awvalid <= 1'b0;
        req.wvalid  <= 1'b0;
        do begin
            @(negedge clk);
        end while (!rsp.bvalid);
        resp = rsp.bresp;
        repeat (stall) begin
            @(negedge clk);
            if (!rsp.bvalid || rsp.bresp !== resp)
                report_failure("write response changed while bready was low");
            if (rsp.awready || rsp.wready)
                report_failure("write channel ready while a response was pending");
        end
        @(posedge clk);
        req.bready <= 1'b1;
        @(posedge clk);
        req.bready <= 1'b0;
        @(negedge clk);
        if (rsp.bvalid)
            report_failure("write response still valid after it was accepted");
        if (resp !== expected)
            report_mismatch($sformatf("bresp at 0x%02h", addr), 32'(resp), 32'(expected));
    endtask

    task automatic bus_read(input logic [7:0] addr, input axil_resp_t expected,
                            output logic [31:0] data);
        int         stall;
        axil_resp_t resp;
        stall = stall_cycles();
        @(posedge clk);
        req.arvalid <= 1'b1;
        req.araddr  <= addr;
        do begin
            @(negedge clk);
        end while (!rsp.arready);
        @(posedge clk);
        req.arvalid <= 1'b0;
        do begin
            @(negedge clk);
        end while (!rsp.rvalid);
        data = rsp.rdata;
        resp = rsp.rresp;
        repeat (stall) begin
            @(negedge clk);
            if (!rsp.rvalid || rsp.rdata !== data || rsp.rresp !== resp)
                report_failure("read response changed while rready was low");
        end
        @(posedge clk);
        req.rready <= 1'b1;
        @(posedge clk);
        req.rready <= 1'b0;
        @(negedge clk);
        if (rsp.rvalid)
            report_failure("read response still valid after it was accepted");
        if (resp !== expected)
            report_mismatch($sformatf("rresp at 0x%02h", addr), 32'(resp), 32'(expected));
    endtask

    // one full operation over the bus, checked against the command rules
    task automatic run_op(input alu_cmd_e cmd, input logic [15:0] a, input logic [15:0] b);
        logic [31:0] rd;
        logic [16:0] sum;
        logic [15:0] exp_res;
        logic        exp_carry;
        logic        check_res;
        logic        check_carry;
        check_res   = 1'b1;
        check_carry = 1'b1;
        exp_carry   = 1'b0;
        sum         = {1'b0, a} + {1'b0, b};
        case (cmd)
            ADD: begin
                exp_res   = sum[15:0];
                exp_carry = sum[16];
            end
            SUB: begin
                exp_res   = a - b;
                exp_carry = (a >= b);
            end
            COMP: begin
                exp_res   = '0;
                exp_carry = (a > b);
                check_res = 1'b0; // compare is judged by its carry alone
            end
            default: begin
                check_carry = 1'b0; // carry has no meaning for logic and shift
                case (cmd)
                    XOR:     exp_res = a ^ b;
                    XNOR:    exp_res = ~(a ^ b);
                    AND:     exp_res = a & b;
                    OR:      exp_res = a | b;
                    default: exp_res = b >> 1; // a zero enters at the top
                endcase
            end
        endcase
        bus_write(REG_OPA, {16'h0, a}, RESP_OKAY);
        bus_write(REG_OPB, {16'h0, b}, RESP_OKAY);
        bus_write(REG_CMD, {27'h0, cmd}, RESP_OKAY);
        bus_read(REG_RESULT, RESP_OKAY, rd);
        if (check_res && rd !== {16'h0, exp_res})
            report_mismatch($sformatf("result of %s", cmd.name()), rd, {16'h0, exp_res});
        if (check_res)
            model_result = exp_res;
        bus_read(REG_FLAGS, RESP_OKAY, rd);
        if (check_carry && rd[FLAG_CARRY] !== exp_carry)
            report_mismatch($sformatf("carry of %s", cmd.name()), 32'(rd[FLAG_CARRY]),
                            32'(exp_carry));
        if (check_res && rd[FLAG_ZERO] !== (exp_res == '0))
            report_mismatch($sformatf("zero of %s", cmd.name()), 32'(rd[FLAG_ZERO]),
                            32'(exp_res == '0));
    endtask

    initial begin
        logic [15:0] a;
        logic [15:0] b;
        logic [31:0] rd;
        arst_n = 1'b0;
        req    = '0;
        repeat (16) @(posedge clk);
        arst_n <= 1'b1;
        @(negedge clk);
        if (!rsp.awready || !rsp.wready || !rsp.arready || rsp.bvalid || rsp.rvalid)
            report_failure("handshake signals not idle after reset");
        bus_read(REG_CMD, RESP_OKAY, rd);
        if (rd !== 32'h0)
            report_mismatch("command after reset", rd, 32'h0);

        for (int i = 0; i < N_ADDSUB; i++) begin
            a = 16'($random(seed));
            b = 16'($random(seed));
            run_op(ADD, a, b);
            run_op(SUB, a, b);
        end

        for (int c = 0; c < 4; c++) begin
            for (int i = 0; i < N_RAND; i++) begin
                a = 16'($random(seed));
                b = 16'($random(seed));
                run_op(LOGIC_CMDS[c], a, b);
            end
            run_op(LOGIC_CMDS[c], a, a);  // zero result for xor
            run_op(LOGIC_CMDS[c], a, ~a); // zero result for xnor and and
        end

        for (int i = 0; i < N_RAND; i++) begin
            a = 16'($random(seed));
            b = 16'($random(seed));
            if (a == b)
                b = a + 16'd1;
            run_op(COMP, a, b);
        end

        for (int i = 0; i < N_RAND; i++)
            run_op(RSHFT, 16'($random(seed)), 16'($random(seed)));
        for (int i = 0; i < 8; i++)
            run_op(RSHFT, 16'($random(seed)), SHIFT_PATTERNS[i]); // bits cross slice edges

        run_op(ADD, 16'h1234, 16'h4321);
        bus_write(REG_CMD, 32'h0000_001F, RESP_SLVERR);
        bus_write(REG_CMD, 32'h0000_0001, RESP_SLVERR);
        bus_write(REG_RESULT, 32'h0000_FFFF, RESP_SLVERR);
        bus_write(REG_FLAGS, 32'h0000_0003, RESP_SLVERR);
        bus_write(8'h14, 32'h0000_0001, RESP_SLVERR);
        bus_read(8'h20, RESP_SLVERR, rd);
        if (rd !== 32'h0)
            report_mismatch("data of unmapped read", rd, 32'h0);
        bus_read(REG_RESULT, RESP_OKAY, rd);
        if (rd !== {16'h0, model_result})
            report_mismatch("result after bus errors", rd, {16'h0, model_result});
        bus_read(REG_CMD, RESP_OKAY, rd);
        if (rd !== {27'h0, ADD})
            report_mismatch("command after bus errors", rd, {27'h0, ADD});

        max_stall = 12;
        for (int i = 0; i < N_STALL; i++) begin
            a = 16'($random(seed));
            b = 16'($random(seed));
            run_op(ADD, a, b);
            run_op(SUB, a, b);
        end

        $display("Errors: %0d mismatches, %0d protocol failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("Watchdog expired after %0d cycles, the DUT stopped responding", TIMEOUT);
        $display("Errors: %0d mismatches, %0d protocol failures", mismatches, failures + 1);
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- logic/alu_bit_cell.sv
`default_nettype none

module alu_bit_cell (
    input  logic               data1,
    input  logic               data2,
    input  logic               carry_in,
    input  logic               direct_in, // neighbour bit for the shift
    input  alu_pkg::alu_ctrl_t ctrl,
    output logic               ret,
    output logic               gen,
    output logic               propagate,
    output logic               d2_inv
);

    logic carry;
    logic interm;
    logic picked;

    assign d2_inv = data2 ^ ctrl.b_inv; // b is inverted for subtract and compare
    assign carry  = carry_in & ~ctrl.carry_disable;

    assign gen       = data1 & d2_inv;
    assign propagate = data1 | d2_inv;
    assign interm    = ~gen & propagate; // plain xor of the two operand bits

    always_comb begin
        case (ctrl.sel)
            2'b00:   picked = interm;
            2'b01:   picked = gen;
            2'b10:   picked = propagate;
            default: picked = direct_in;
        endcase
    end

    // the sum bit when the carry is enabled, the logic bit otherwise
    assign ret = picked ^ carry;

endmodule

`default_nettype wire

//--- logic/alu_nibble.sv
`default_nettype none

module alu_nibble (
    input  logic               [3:0] d1,
    input  logic               [3:0] d2,
    input  alu_pkg::alu_word_t       op,
    input  logic                     carry_in,
    output logic               [3:0] res,
    output logic                     carry_out
);

    import alu_pkg::*;

    logic [3:0] gen;
    logic [3:0] propagate;
    logic [4:0] d2_inv;     // bit 4 is the bit shifted in from the next slice
    logic [4:0] carry;
    alu_ctrl_t  cell_ctrl;

    always_comb begin
        cell_ctrl          = op.ctrl;
        cell_ctrl.carry_in = carry_in; // the chained carry replaces the command's own bit
    end

    assign d2_inv[4] = carry_in;
    assign carry[0]  = carry_in;
    assign carry_out = carry[4];

    for (genvar i = 0; i < 4; i++) begin : g_bit
        alu_bit_cell u_cell (
            .data1     (d1[i]),
            .data2     (d2[i]),
            .carry_in  (carry[i]),
            .direct_in (d2_inv[i+1]),
            .ctrl      (cell_ctrl),
            .ret       (res[i]),
            .gen       (gen[i]),
            .propagate (propagate[i]),
            .d2_inv    (d2_inv[i])
        );
    end

    // every carry is a flat sum of products of generate and propagate terms
    assign carry[1] = gen[0] | (propagate[0] & carry[0]);

    assign carry[2] = gen[1] | (propagate[1] & gen[0])
                    | (propagate[1] & propagate[0] & carry[0]);

    assign carry[3] = gen[2] | (propagate[2] & gen[1])
                    | (propagate[2] & propagate[1] & gen[0])
                    | (propagate[2] & propagate[1] & propagate[0] & carry[0]);

    assign carry[4] = gen[3] | (propagate[3] & gen[2])
                    | (propagate[3] & propagate[2] & gen[1])
                    | (propagate[3] & propagate[2] & propagate[1] & gen[0])
                    | (propagate[3] & propagate[2] & propagate[1] & propagate[0] & carry[0]);

endmodule

`default_nettype wire

//--- logic/alu_pkg.sv
`default_nettype none

package alu_pkg;

    // a command code is also the control word of every slice
    typedef enum logic [4:0] {
        ADD   = 5'b00000,
        SUB   = 5'b11000, // carry in set and operand b inverted
        XOR   = 5'b00100,
        XNOR  = 5'b01100, // acts as NOT when opa is zero
        COMP  = 5'b01000, // computes a - b - 1 so the carry means a > b
        AND   = 5'b00101,
        OR    = 5'b00110,
        RSHFT = 5'b00111  // opb moves one bit to the right and opa does not matter
    } alu_cmd_e;

    typedef struct packed {
        logic       carry_in;      // carry into bit 0 of the lowest slice
        logic       b_inv;         // invert the second operand
        logic       carry_disable; // keep the carry away from the result bits
        logic [1:0] sel;           // and-not-or, and, or, direct bit
    } alu_ctrl_t;

    typedef union packed {
        alu_cmd_e  cmd;
        alu_ctrl_t ctrl;
    } alu_word_t;

    // only the eight listed codes are accepted by the register bank
    function automatic logic alu_cmd_legal(input logic [4:0] code);
        case (code)
            ADD, SUB, XOR, XNOR, COMP, AND, OR, RSHFT: return 1'b1;
            default: return 1'b0;
        endcase
    endfunction

endpackage

`default_nettype wire

//--- logic/alu_regs.sv
`default_nettype none

module alu_regs #(
    parameter int WIDTH = 16 // at most the bus data width
) (
    input  logic                           clk,
    input  logic                           arst_n,
    input  bus_pkg::axil_req_t             req,
    output bus_pkg::axil_rsp_t             rsp,
    output logic               [WIDTH-1:0] opa,
    output logic               [WIDTH-1:0] opb,
    output alu_pkg::alu_word_t             op,
    input  logic               [WIDTH-1:0] result,
    input  logic                           carry_out
);

    import alu_pkg::*;
    import bus_pkg::*;

    logic [WIDTH-1:0]  opa_q;
    logic [WIDTH-1:0]  opb_q;
    alu_word_t         op_q;
    logic [WIDTH-1:0]  result_q;
    logic              carry_q;
    logic              zero_q;

    logic              wr_pend_q;  // write taken, response goes out next edge
    logic              capture_q;  // the pending write started an operation
    logic              bvalid_q;
    axil_resp_t        bresp_q;
    logic              rvalid_q;
    logic [DATA_W-1:0] rdata_q;
    axil_resp_t        rresp_q;

    logic              wr_accept;
    logic              ar_accept;
    logic              cmd_legal;
    logic              wr_ok;
    logic              wr_cmd;
    logic [DATA_W-1:0] rd_data;
    axil_resp_t        rd_resp;

    assign wr_accept = req.awvalid & req.wvalid & ~wr_pend_q & ~bvalid_q;
    assign ar_accept = req.arvalid & ~rvalid_q;
    assign cmd_legal = (req.wdata[DATA_W-1:5] == '0) & alu_cmd_legal(req.wdata[4:0]);

    always_comb begin
        wr_ok  = 1'b0;
        wr_cmd = 1'b0;
        case (req.awaddr)
            REG_OPA, REG_OPB: wr_ok = 1'b1;
            REG_CMD: begin
                wr_ok  = cmd_legal; // an illegal code leaves the command as it was
                wr_cmd = cmd_legal;
            end
            default: wr_ok = 1'b0; // result, flags and holes are not writable
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            opa_q <= '0;
            opb_q <= '0;
            op_q  <= '0; // ADD
        end else if (wr_accept) begin
            case (req.awaddr)
                REG_OPA: opa_q <= req.wdata[WIDTH-1:0];
                REG_OPB: opb_q <= req.wdata[WIDTH-1:0];
                REG_CMD: if (cmd_legal) op_q <= req.wdata[4:0];
                default: ;
            endcase
        end
    end

    // the ALU settles within the cycle after the command is loaded
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            result_q <= '0;
            carry_q  <= 1'b0;
            zero_q   <= 1'b0;
        end else if (capture_q) begin
            result_q <= result;
            carry_q  <= carry_out;
            zero_q   <= (result == '0);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_pend_q <= 1'b0;
            capture_q <= 1'b0;
            bvalid_q  <= 1'b0;
            bresp_q   <= RESP_OKAY;
        end else begin
            capture_q <= wr_accept & wr_cmd;
            if (wr_accept) begin
                wr_pend_q <= 1'b1;
                bresp_q   <= wr_ok ? RESP_OKAY : RESP_SLVERR;
            end else if (wr_pend_q) begin
                wr_pend_q <= 1'b0;
                bvalid_q  <= 1'b1; // same edge as the result capture
            end else if (bvalid_q && req.bready) begin
                bvalid_q <= 1'b0;
            end
        end
    end

    always_comb begin
        rd_data = '0;
        rd_resp = RESP_OKAY;
        case (req.araddr)
            REG_OPA:    rd_data = DATA_W'(opa_q);
            REG_OPB:    rd_data = DATA_W'(opb_q);
            REG_CMD:    rd_data = DATA_W'(op_q);
            REG_RESULT: rd_data = DATA_W'(result_q);
            REG_FLAGS: begin
                rd_data[FLAG_CARRY] = carry_q;
                rd_data[FLAG_ZERO]  = zero_q;
            end
            default:    rd_resp = RESP_SLVERR;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rvalid_q <= 1'b0;
            rdata_q  <= '0;
            rresp_q  <= RESP_OKAY;
        end else if (ar_accept) begin
            rvalid_q <= 1'b1;
            rdata_q  <= rd_data;
            rresp_q  <= rd_resp;
        end else if (rvalid_q && req.rready) begin
            rvalid_q <= 1'b0;
        end
    end

    always_comb begin
        rsp         = '0;
        rsp.awready = ~wr_pend_q & ~bvalid_q;
        rsp.wready  = ~wr_pend_q & ~bvalid_q;
        rsp.bvalid  = bvalid_q;
        rsp.bresp   = bresp_q;
        rsp.arready = ~rvalid_q;
        rsp.rvalid  = rvalid_q;
        rsp.rdata   = rdata_q;
        rsp.rresp   = rresp_q;
    end

    assign opa = opa_q;
    assign opb = opb_q;
    assign op  = op_q;

    // the response for an accepted write shows up exactly two edges later
    a_b_timing: assert property (@(posedge clk) disable iff (!arst_n)
        wr_accept |=> !rsp.bvalid ##1 rsp.bvalid);

    a_b_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rsp.bvalid && !req.bready |=> rsp.bvalid && $stable(rsp.bresp));

    a_r_hold: assert property (@(posedge clk) disable iff (!arst_n)
        rsp.rvalid && !req.rready |=> rsp.rvalid && $stable(rsp.rdata)
                                      && $stable(rsp.rresp));

    // registers stay put while a write response waits for bready
    a_no_wr_in_b: assert property (@(posedge clk) disable iff (!arst_n)
        rsp.bvalid |=> $stable(opa_q) && $stable(opb_q) && $stable(op_q));

endmodule

`default_nettype wire

//--- logic/alu_wide.sv
`default_nettype none

module alu_wide #(
    parameter int WIDTH = 16 // a multiple of 4
) (
    input  logic               [WIDTH-1:0] opa,
    input  logic               [WIDTH-1:0] opb,
    input  alu_pkg::alu_word_t             op,
    output logic               [WIDTH-1:0] result,
    output logic                           carry_out
);

    import alu_pkg::*;

    localparam int SLICES = WIDTH / 4;

    logic [SLICES-1:0] slice_cin;
    logic [SLICES-1:0] slice_cout;
    logic              is_shift;

    assign is_shift = (op.cmd == RSHFT);

    for (genvar k = 0; k < SLICES; k++) begin : g_slice
        logic chain_in;
        logic shift_in;

        // ripple carry between slices for the arithmetic commands
        if (k == 0) begin : g_first
            assign chain_in = op.ctrl.carry_in;
        end else begin : g_next
            assign chain_in = slice_cout[k-1];
        end

        // lowest opb bit of the slice above, a zero enters at the very top
        if (k == SLICES - 1) begin : g_top
            assign shift_in = 1'b0;
        end else begin : g_low
            assign shift_in = opb[4*(k+1)];
        end

        assign slice_cin[k] = is_shift ? shift_in : chain_in;

        alu_nibble u_nibble (
            .d1        (opa[4*k +: 4]),
            .d2        (opb[4*k +: 4]),
            .op        (op),
            .carry_in  (slice_cin[k]),
            .res       (result[4*k +: 4]),
            .carry_out (slice_cout[k])
        );
    end

    // logic commands disable the carry so the flag is only meaningful for arithmetic
    assign carry_out = slice_cout[SLICES-1];

endmodule

`default_nettype wire

//--- logic/bus_pkg.sv
`default_nettype none

package bus_pkg;

    localparam int ADDR_W = 8;
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    typedef logic [1:0] axil_resp_t;

    localparam axil_resp_t RESP_OKAY   = 2'b00;
    localparam axil_resp_t RESP_SLVERR = 2'b10;

    // register map of the peripheral
    localparam logic [ADDR_W-1:0] REG_OPA    = 8'h00;
    localparam logic [ADDR_W-1:0] REG_OPB    = 8'h04;
    localparam logic [ADDR_W-1:0] REG_CMD    = 8'h08; // a write here starts the operation
    localparam logic [ADDR_W-1:0] REG_RESULT = 8'h0C;
    localparam logic [ADDR_W-1:0] REG_FLAGS  = 8'h10;

    // bit positions inside REG_FLAGS
    localparam int FLAG_CARRY = 0;
    localparam int FLAG_ZERO  = 1;

    typedef struct packed {
        logic              awvalid;
        logic [ADDR_W-1:0] awaddr;
        logic              wvalid;
        logic [DATA_W-1:0] wdata;
        logic [STRB_W-1:0] wstrb; // not used by the slave since all writes are full words
        logic              bready;
        logic              arvalid;
        logic [ADDR_W-1:0] araddr;
        logic              rready;
    } axil_req_t;

    typedef struct packed {
        logic              awready;
        logic              wready;
        logic              bvalid;
        axil_resp_t        bresp;
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        axil_resp_t        rresp;
    } axil_rsp_t;

endpackage

`default_nettype wire

//--- logic/sliced_alu_top.sv
`default_nettype none

module sliced_alu_top #(
    parameter int WIDTH = 16
) (
    input  logic               clk,
    input  logic               arst_n,
    input  bus_pkg::axil_req_t req,
    output bus_pkg::axil_rsp_t rsp
);

    import alu_pkg::*;

    logic [WIDTH-1:0] opa;
    logic [WIDTH-1:0] opb;
    alu_word_t        op;
    logic [WIDTH-1:0] result;
    logic             carry_out;

    alu_regs #(.WIDTH(WIDTH)) u_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (req),
        .rsp       (rsp),
        .opa       (opa),
        .opb       (opb),
        .op        (op),
        .result    (result),
        .carry_out (carry_out)
    );

    // purely combinational, the register bank samples its outputs
    alu_wide #(.WIDTH(WIDTH)) u_alu (
        .opa       (opa),
        .opb       (opb),
        .op        (op),
        .result    (result),
        .carry_out (carry_out)
    );

endmodule

`default_nettype wire

//--- sliced_alu.f
logic/alu_pkg.sv
logic/bus_pkg.sv
logic/alu_bit_cell.sv
logic/alu_nibble.sv
logic/alu_wide.sv
logic/alu_regs.sv
logic/sliced_alu_top.sv
bench/sliced_alu_tb.sv
